/* verilog/opcodes.sv */
`default_nettype none

package opcodes;

   typedef logic [15:0] Word_t;

   // Instruction bits 15:11
   typedef enum logic [4:0] {
      ADD    = 5'd0,  ADDI   = 5'd1,  ADDIB  = 5'd2,  ADC    = 5'd3,
      ADCI   = 5'd4,  SUB    = 5'd5,  SUBI   = 5'd6,  SUBIB  = 5'd7,
      SUC    = 5'd8,  SUCI   = 5'd9,  LLI    = 5'd10, LUI    = 5'd11,
      LDW    = 5'd12, STW    = 5'd13, BR     = 5'd14, BNE    = 5'd15,
      BE     = 5'd16, BLT    = 5'd17, BGE    = 5'd18, BWL    = 5'd19,
      JMP    = 5'd20, PUSH_POP = 5'd21, RET  = 5'd22, RSV23  = 5'd23,
      RSV24  = 5'd24, RSV25  = 5'd25, RSV26  = 5'd26, RSV27  = 5'd27,
      RSV28  = 5'd28, RSV29  = 5'd29, RSV30  = 5'd30, RSV31  = 5'd31
   } Opcode_t;

   typedef enum logic [2:0] {
      FnNOP = 3'd0,
      FnADD = 3'd1,
      FnADC = 3'd2,
      FnSUB = 3'd3,
      FnSUC = 3'd4,
      FnIMM = 3'd5,   // Pass operand 2
      FnUPR = 3'd6,   // Operand 2 into high byte
      FnMEM = 3'd7    // Pass operand 1
   } alu_functions_t;

   typedef enum logic {Op1Rd1, Op1Pc} Op1_select_t;

   typedef enum logic {Op2Rd2, Op2Imm} Op2_select_t;

   // Short is imm5 sign extended, long is imm8 zero extended
   typedef enum logic {ImmShort, ImmLong} Imm_select_t;

   typedef enum logic {WdAlu, WdSys} Wd_select_t;

   // Read port 1 address from rs or rd field
   typedef enum logic {Rs1Ra, Rs1Rd} Rs1_select_t;

   typedef enum logic {Pc1, PcSysbus} pc_select_t;

   // Bit positions in the flag word
   localparam int FLAGS_C = 0;
   localparam int FLAGS_Z = 1;
   localparam int FLAGS_N = 2;
   localparam int FLAGS_V = 3;

endpackage

`default_nettype wire

/* verilog/alu.sv */
`default_nettype none

module alu (
   input  wire opcodes::alu_functions_t AluOp,
   input  wire opcodes::Word_t          A,
   input  wire opcodes::Word_t          B,
   input  wire                          CFlag,
   output opcodes::Word_t               Result,
   output logic [3:0]                   Flags
);

   import opcodes::*;

   Word_t       addend;   // B, inverted when subtracting
   logic        carryIn;
   logic        arith;
   logic [16:0] sum;

   always_comb begin
      addend  = B;
      carryIn = 1'b0;
      arith   = 1'b1;
      case (AluOp)
         FnADD: carryIn = 1'b0;
         FnADC: carryIn = CFlag;
         FnSUB: begin
            addend  = ~B;
            carryIn = 1'b1;
         end
         FnSUC: begin
            addend  = ~B;
            carryIn = CFlag;   // Carry set means no borrow
         end
         default: arith = 1'b0;
      endcase
   end

   assign sum = {1'b0, A} + {1'b0, addend} + {16'h0000, carryIn};

   always_comb begin
      case (AluOp)
         FnADD, FnADC, FnSUB, FnSUC: Result = sum[15:0];
         FnIMM: Result = B;
         FnUPR: Result = {B[7:0], A[7:0]};
         FnMEM: Result = A;
         default: Result = '0;
      endcase
      Flags          = '0;
      Flags[FLAGS_C] = arith & sum[16];
      Flags[FLAGS_Z] = (Result == '0);
      Flags[FLAGS_N] = Result[15];
      Flags[FLAGS_V] = arith & (A[15] == addend[15]) & (sum[15] != A[15]);
   end

endmodule

`default_nettype wire

/* verilog/registerFile.sv */
`default_nettype none

module registerFile (
   input  wire [2:0]           Ra1,
   input  wire [2:0]           Ra2,
   input  wire [2:0]           Wa,
   input  wire opcodes::Word_t Wd,
   input  wire                 We,
   output opcodes::Word_t      Rd1,
   output opcodes::Word_t      Rd2,
   input  wire                 Clock,
   input  wire                 nReset
);

   import opcodes::*;

   Word_t regs [8];

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         for (int i = 0; i < 8; i++)
            regs[i] <= '0;
      end else if (We) begin
         regs[Wa] <= Wd;
      end
   end

   assign Rd1 = regs[Ra1];   // Combinational reads
   assign Rd2 = regs[Ra2];

endmodule

`default_nettype wire

/* verilog/datapath.sv */
`default_nettype none

module datapath #(
   parameter opcodes::Word_t ResetAddress = 16'h0000
) (
   input  wire opcodes::Op1_select_t Op1Sel,
   input  wire opcodes::Op2_select_t Op2Sel,
   input  wire opcodes::Imm_select_t ImmSel,
   input  wire opcodes::Rs1_select_t Rs1Sel,
   input  wire opcodes::Wd_select_t  WdSel,
   input  wire opcodes::pc_select_t  PcSel,
   input  wire                       PcWe,
   input  wire                       PcEn,
   input  wire                       AluEn,
   input  wire                       AluWe,
   input  wire                       IrWe,
   input  wire                       RegWe,
   input  wire                       MemEn,
   input  wire                       ENB,
   input  wire opcodes::Word_t       AluResult,
   output opcodes::Word_t            AluA,
   output opcodes::Word_t            AluB,
   input  wire opcodes::Word_t       Rd1,
   input  wire opcodes::Word_t       Rd2,
   output logic [2:0]                Ra1,
   output logic [2:0]                Ra2,
   output logic [2:0]                Wa,
   output opcodes::Word_t            Wd,
   output logic                      RfWe,
   input  wire opcodes::Word_t       DataIn,
   output opcodes::Word_t            AdOut,
   output logic [7:0]                OpcodeCondIn,
   input  wire                       Clock,
   input  wire                       nReset
);

   import opcodes::*;

   Word_t pc;
   Word_t ir;
   Word_t aluLatch;
   Word_t inLatch;   // Captured bus read data
   Word_t imm;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         pc <= ResetAddress;
         ir <= '0;
      end else begin
         if (PcWe)
            pc <= (PcSel == Pc1) ? pc + 16'd1 : inLatch;
         if (IrWe)
            ir <= inLatch;
      end
   end

   always_ff @(posedge Clock) begin
      if (AluWe)
         aluLatch <= AluResult;
      if (ENB && MemEn)
         inLatch <= DataIn;
   end

   assign imm = (ImmSel == ImmShort) ? {{11{ir[4]}}, ir[4:0]} : {8'h00, ir[7:0]};

   assign AluA = (Op1Sel == Op1Pc) ? pc : Rd1;
   assign AluB = (Op2Sel == Op2Imm) ? imm : Rd2;

   assign Ra1  = (Rs1Sel == Rs1Rd) ? ir[10:8] : ir[7:5];
   assign Ra2  = ir[7:5];
   assign Wa   = ir[10:8];
   assign Wd   = (WdSel == WdSys) ? inLatch : AluResult;
   assign RfWe = RegWe;

   // Bus idles at zero when nothing is driven
   assign AdOut = PcEn ? pc : (AluEn ? aluLatch : '0);

   assign OpcodeCondIn = ir[15:8];

endmodule

`default_nettype wire

/* verilog/control.sv */
`default_nettype none

module control (
   output opcodes::alu_functions_t AluOp,
   output opcodes::Op1_select_t    Op1Sel,
   output opcodes::Op2_select_t    Op2Sel,
   output opcodes::Imm_select_t    ImmSel,
   output opcodes::Rs1_select_t    Rs1Sel,
   output opcodes::Wd_select_t     WdSel,
   output opcodes::pc_select_t     PcSel,
   output logic                    AluEn,
   output logic                    AluWe,
   output logic                    PcWe,
   output logic                    PcEn,
   output logic                    IrWe,
   output logic                    RegWe,
   output logic                    MemEn,    // Bus pads turned to input
   output logic                    ENB,
   output logic                    ALE,
   output logic                    nME,
   output logic                    nOE,
   output logic                    nWE,
   output logic                    CFlag,
   input  wire  [7:0]              OpcodeCondIn,
   input  wire  [3:0]              Flags,
   input  wire                     Clock,
   input  wire                     nReset
);

   import opcodes::*;

   Opcode_t    opcode;
   logic       loadStore;
   logic       statusWe;
   logic [3:0] statusReg;

   enum logic {fetch, execute} state;
   enum logic [1:0] {fet1, fet2, fet3, fet4} fetchSub;
   enum logic [2:0] {exe1, exe2, exe3, exe4, exe5} executeSub;

   assign opcode    = Opcode_t'(OpcodeCondIn[7:3]);
   assign loadStore = (opcode == LDW) || (opcode == STW);

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         statusReg <= '0;
      end else if (statusWe) begin
         statusReg <= Flags;
      end
   end

   assign CFlag = statusReg[FLAGS_C];

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         state      <= fetch;
         fetchSub   <= fet1;
         executeSub <= exe1;
      end else if (state == fetch) begin
         case (fetchSub)
            fet1: fetchSub <= fet2;
            fet2: fetchSub <= fet3;
            fet3: fetchSub <= fet4;
            default: begin
               fetchSub   <= fet1;
               executeSub <= exe1;
               state      <= execute;
            end
         endcase
      end else begin
         case (executeSub)
            exe1: executeSub <= exe2;
            exe2: executeSub <= exe3;
            exe3: executeSub <= exe4;
            exe4: executeSub <= exe5;
            default: executeSub <= exe1;
         endcase
         if (!loadStore || executeSub == exe5) begin   // Instruction done
            state      <= fetch;
            executeSub <= exe1;
         end
      end
   end

   always_comb begin
      AluOp    = FnNOP;
      Op1Sel   = Op1Rd1;
      Op2Sel   = Op2Rd2;
      ImmSel   = ImmLong;
      Rs1Sel   = Rs1Ra;
      WdSel    = WdAlu;
      PcSel    = Pc1;
      AluEn    = 1'b0;
      AluWe    = 1'b0;
      PcWe     = 1'b0;
      PcEn     = 1'b0;
      IrWe     = 1'b0;
      RegWe    = 1'b0;
      MemEn    = 1'b0;
      ENB      = 1'b0;
      ALE      = 1'b0;
      nME      = 1'b1;
      nOE      = 1'b1;
      nWE      = 1'b1;
      statusWe = 1'b0;
      if (state == fetch) begin
         case (fetchSub)
            fet1: begin
               ALE  = 1'b1;
               PcEn = 1'b1;   // PC is the fetch address
            end
            fet2: begin
               nME   = 1'b0;
               nOE   = 1'b0;
               MemEn = 1'b1;
            end
            fet3: begin
               nME   = 1'b0;
               nOE   = 1'b0;
               MemEn = 1'b1;
               ENB   = 1'b1;
            end
            default: begin
               MemEn = 1'b1;
               IrWe  = 1'b1;
            end
         endcase
      end else begin
         case (executeSub)
            exe1: begin
               case (opcode)
                  // Two-address ops, rd <= rd op rs (or rd op imm5)
                  ADD, ADDI, ADC, SUB, SUBI, SUC: begin
                     Rs1Sel   = Rs1Rd;
                     RegWe    = 1'b1;
                     statusWe = 1'b1;
                     if (opcode == ADDI || opcode == SUBI) begin
                        Op2Sel = Op2Imm;
                        ImmSel = ImmShort;
                     end
                     case (opcode)
                        ADC: AluOp = FnADC;
                        SUB, SUBI: AluOp = FnSUB;
                        SUC: AluOp = FnSUC;
                        default: AluOp = FnADD;
                     endcase
                  end
                  LLI, LUI: begin
                     Rs1Sel = Rs1Rd;   // LUI keeps the low byte of rd
                     Op2Sel = Op2Imm;
                     RegWe  = 1'b1;
                     AluOp  = (opcode == LUI) ? FnUPR : FnIMM;
                  end
                  LDW, STW: begin
                     Op2Sel = Op2Imm;   // Address is rs + imm5
                     ImmSel = ImmShort;
                     AluOp  = FnADD;
                     AluWe  = 1'b1;
                  end
                  default: ;
               endcase
               PcWe = !loadStore;
            end
            exe2: begin
               ALE   = 1'b1;
               AluEn = 1'b1;
            end
            exe3: begin
               AluEn = 1'b1;
               if (opcode == LDW) begin
                  nME   = 1'b0;
                  nOE   = 1'b0;
                  MemEn = 1'b1;
               end else begin
                  Rs1Sel = Rs1Rd;   // Store data into the latch
                  AluOp  = FnMEM;
                  AluWe  = 1'b1;
               end
            end
            exe4: begin
               if (opcode == LDW) begin
                  nME   = 1'b0;
                  nOE   = 1'b0;
                  MemEn = 1'b1;
                  ENB   = 1'b1;
               end else begin
                  AluEn = 1'b1;
               end
            end
            default: begin
               PcWe = 1'b1;
               if (opcode == LDW) begin
                  MemEn = 1'b1;
                  WdSel = WdSys;
                  RegWe = 1'b1;
               end else begin
                  AluEn = 1'b1;
                  nME   = 1'b0;
                  nWE   = 1'b0;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* verilog/cpu16.sv */
`default_nettype none

module cpu16 #(
   parameter opcodes::Word_t ResetAddress = 16'h0000
) (
   input  wire                 Clock,
   input  wire                 nReset,
   input  wire opcodes::Word_t DataIn,
   output opcodes::Word_t      AdOut,
   output logic                ALE,
   output logic                nME,
   output logic                nOE,
   output logic                nWE
);

   import opcodes::*;

   alu_functions_t aluOp;
   Op1_select_t    op1Sel;
   Op2_select_t    op2Sel;
   Imm_select_t    immSel;
   Rs1_select_t    rs1Sel;
   Wd_select_t     wdSel;
   pc_select_t     pcSel;
   logic           aluEn, aluWe, pcWe, pcEn, irWe, regWe, memEn, enb, cFlag, rfWe;
   logic [7:0]     opcodeCond;
   logic [3:0]     flags;
   logic [2:0]     ra1, ra2, wa;
   Word_t          aluA, aluB, aluResult, rd1, rd2, wd;

   control control0 (
      .AluOp(aluOp), .Op1Sel(op1Sel), .Op2Sel(op2Sel), .ImmSel(immSel),
      .Rs1Sel(rs1Sel), .WdSel(wdSel), .PcSel(pcSel), .AluEn(aluEn),
      .AluWe(aluWe), .PcWe(pcWe), .PcEn(pcEn), .IrWe(irWe), .RegWe(regWe),
      .MemEn(memEn), .ENB(enb), .ALE(ALE), .nME(nME), .nOE(nOE), .nWE(nWE),
      .CFlag(cFlag), .OpcodeCondIn(opcodeCond), .Flags(flags),
      .Clock(Clock), .nReset(nReset)
   );

   datapath #(.ResetAddress(ResetAddress)) datapath0 (
      .Op1Sel(op1Sel), .Op2Sel(op2Sel), .ImmSel(immSel), .Rs1Sel(rs1Sel),
      .WdSel(wdSel), .PcSel(pcSel), .PcWe(pcWe), .PcEn(pcEn), .AluEn(aluEn),
      .AluWe(aluWe), .IrWe(irWe), .RegWe(regWe), .MemEn(memEn), .ENB(enb),
      .AluResult(aluResult), .AluA(aluA), .AluB(aluB), .Rd1(rd1), .Rd2(rd2),
      .Ra1(ra1), .Ra2(ra2), .Wa(wa), .Wd(wd), .RfWe(rfWe), .DataIn(DataIn),
      .AdOut(AdOut), .OpcodeCondIn(opcodeCond), .Clock(Clock), .nReset(nReset)
   );

   registerFile registerFile0 (
      .Ra1(ra1), .Ra2(ra2), .Wa(wa), .Wd(wd), .We(rfWe), .Rd1(rd1), .Rd2(rd2),
      .Clock(Clock), .nReset(nReset)
   );

   alu alu0 (
      .AluOp(aluOp), .A(aluA), .B(aluB), .CFlag(cFlag), .Result(aluResult),
      .Flags(flags)
   );

endmodule

`default_nettype wire

/* tb/sysBusMemory.sv */
`default_nettype none

module sysBusMemory #(
   parameter int Depth = 256
) (
   input  wire        Clock,
   input  wire [15:0] AdOut,
   input  wire        ALE,
   input  wire        nME,
   input  wire        nOE,
   input  wire        nWE,
   output logic [15:0] DataIn
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int AddrBits = $clog2(Depth);

   logic [15:0]         mem [Depth];
   logic [AddrBits-1:0] addrLatch;   // Address from the ALE cycle

   always @(posedge Clock) begin
      if (ALE)
         addrLatch <= AdOut[AddrBits-1:0];
      if (!nME && !nWE)
         mem[addrLatch] <= AdOut;   // Data phase of a write
   end

   // Read data only while the output enable is asserted
   assign DataIn = (!nME && !nOE) ? mem[addrLatch] : 16'h0000;

endmodule

`default_nettype wire

/* tb/cpu16_assertions.sv */
`default_nettype none

module cpu16_assertions (
   input wire Clock,
   input wire nReset,
   input wire ALE,
   input wire nME,
   input wire nOE,
   input wire nWE
);

   timeunit 1ns;
   timeprecision 1ps;

   logic seenAle;   // First address phase since reset

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         seenAle <= 1'b0;
      else if (ALE)
         seenAle <= 1'b1;
   end

   aleNotInMemCycle: assert property (@(posedge Clock) disable iff (!nReset)
      !(ALE && !nME)) else $error("ALE asserted during a memory cycle");

   readWriteExclusive: assert property (@(posedge Clock) disable iff (!nReset)
      !(!nOE && !nWE)) else $error("nOE and nWE low together");

   idleUntilFirstAle: assert property (@(posedge Clock) disable iff (!nReset)
      !seenAle |-> (nME && nOE && nWE)) else $error("Bus strobe active before first ALE");

endmodule

bind control cpu16_assertions asserts0 (
   .Clock(Clock), .nReset(nReset), .ALE(ALE), .nME(nME), .nOE(nOE), .nWE(nWE)
);

`default_nettype wire

/* tb/cpu16Tb.sv */
`default_nettype none

module cpu16Tb;

   timeunit 1ns;
   timeprecision 1ps;

   import opcodes::*;

   localparam Word_t ResetAddr     = 16'h0010;
   localparam int    TimeoutCycles = 400;   // 284 program cycles over four tests, reset and margin

   logic  Clock;
   logic  nReset;
   Word_t DataIn;
   Word_t AdOut;
   logic  ALE, nME, nOE, nWE;

   Word_t       refMem [256];
   Word_t       refRegs [8];
   logic        refCarry;
   int          gapQ [$];   // Expected ALE spacing per instruction
   int          cycle;
   int          lastAleCycle;
   int          errors;
   int          checks;
   int          testErrors;
   int          progLen;
   logic        seenAle;
   logic [31:0] seed;
   string       testName;

   cpu16 #(.ResetAddress(ResetAddr)) dut0 (
      .Clock(Clock), .nReset(nReset), .DataIn(DataIn), .AdOut(AdOut),
      .ALE(ALE), .nME(nME), .nOE(nOE), .nWE(nWE)
   );

   sysBusMemory #(.Depth(256)) mem0 (
      .Clock(Clock), .AdOut(AdOut), .ALE(ALE), .nME(nME), .nOE(nOE), .nWE(nWE),
      .DataIn(DataIn)
   );

   always #10 Clock = ~Clock;

   task automatic checkValue(string what, Word_t expected, Word_t actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         testErrors++;
         $display("[FAIL] %s: %s expected %h actual %h", testName, what, expected, actual);
      end
   endtask

   function automatic Word_t randomWord();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed[30:15];
   endfunction

   function automatic Word_t encR(Opcode_t op, int rd, int rs, int imm5);
      return {op, 3'(rd), 3'(rs), 5'(imm5)};
   endfunction

   function automatic Word_t encL(Opcode_t op, int rd, int imm8);
      return {op, 3'(rd), 8'(imm8)};
   endfunction

   // Reference interpreter, returns the cycles the program takes
   function automatic int interpret(int count);
      Word_t       pc;
      Word_t       w;
      Word_t       b;
      Word_t       s5;
      logic [16:0] t;
      logic [2:0]  rd;
      logic [2:0]  rs;
      logic        cin;
      logic        arith;
      logic        subtract;
      int          len;
      int          cycles;
      Opcode_t     op;
      pc     = ResetAddr;
      cycles = 0;
      for (int i = 0; i < count; i++) begin
         w        = refMem[pc[7:0]];
         op       = Opcode_t'(w[15:11]);
         rd       = w[10:8];
         rs       = w[7:5];
         s5       = {{11{w[4]}}, w[4:0]};
         b        = '0;
         cin      = 1'b0;   // Carry in, or borrow in when subtracting
         arith    = 1'b1;
         subtract = 1'b0;
         len      = 5;
         case (op)
            ADD:  b = refRegs[rs];
            ADDI: b = s5;
            ADC: begin
               b   = refRegs[rs];
               cin = refCarry;
            end
            SUB: begin
               b        = refRegs[rs];
               subtract = 1'b1;
            end
            SUBI: begin
               b        = s5;
               subtract = 1'b1;
            end
            SUC: begin
               b        = refRegs[rs];
               subtract = 1'b1;
               cin      = !refCarry;   // Borrow is the inverted carry
            end
            default: arith = 1'b0;
         endcase
         case (op)
            LLI: refRegs[rd] = {8'h00, w[7:0]};
            LUI: refRegs[rd] = {w[7:0], refRegs[rd][7:0]};
            LDW: begin
               refRegs[rd] = refMem[8'(refRegs[rs] + s5)];
               len = 9;
            end
            STW: begin
               refMem[8'(refRegs[rs] + s5)] = refRegs[rd];
               len = 9;
            end
            default: ;
         endcase
         if (arith) begin
            if (subtract) begin
               t        = {1'b0, refRegs[rd]} - {1'b0, b} - {16'h0000, cin};
               refCarry = !t[16];
            end else begin
               t        = {1'b0, refRegs[rd]} + {1'b0, b} + {16'h0000, cin};
               refCarry = t[16];
            end
            refRegs[rd] = t[15:0];
         end
         gapQ.push_back(len);
         cycles += len;
         pc = pc + 16'd1;
      end
      return cycles;
   endfunction

   task automatic emit(Word_t w);
      mem0.mem[8'(ResetAddr + 16'(progLen))] = w;
      progLen++;
   endtask

   task automatic beginTest(string name);
      @(negedge Clock);
      nReset     = 1'b0;
      seenAle    = 1'b0;
      testName   = name;
      testErrors = 0;
      progLen    = 0;
      for (int a = 0; a < 256; a++)
         mem0.mem[a] = 16'h7000 | 16'(a);   // BR no-ops tagged with the address
   endtask

   task automatic runTest();
      int cycles;
      for (int a = 0; a < 256; a++)
         refMem[a] = mem0.mem[a];
      for (int r = 0; r < 8; r++)
         refRegs[r] = '0;
      refCarry = 1'b0;
      gapQ.delete();
      cycles = interpret(progLen);
      repeat (2) @(negedge Clock);
      nReset = 1'b1;
      repeat (cycles + 2) @(negedge Clock);
      for (int a = 0; a < 256; a++)
         checkValue($sformatf("mem[%02h]", a), refMem[a], mem0.mem[a]);
      checkValue("unmeasured ALE gaps", 16'h0000, 16'(gapQ.size()));
      $display("Test %s finished with %0d mismatches", testName, testErrors);
   endtask

   // Cycle count, timeout and bus timing monitor
   always @(posedge Clock) begin
      cycle = cycle + 1;
      if (cycle >= TimeoutCycles) begin
         $display("Run stopped after %0d cycles without finishing", cycle);
         $display("Errors found");
         $finish;
      end else if (nReset && ALE && dut0.control0.PcEn) begin
         if (!seenAle)
            checkValue("first fetch address", ResetAddr, AdOut);
         else if (gapQ.size() > 0)
            checkValue("ALE spacing", 16'(gapQ.pop_front()), 16'(cycle - lastAleCycle));
         seenAle      = 1'b1;
         lastAleCycle = cycle;
      end else if (!seenAle) begin
         // Reset cycles count as before the first ALE
         checkValue("strobes before first ALE", 16'h0007, {13'd0, nME, nOE, nWE});
      end
   end

   initial begin
      Clock    = 1'b0;
      nReset   = 1'b0;
      cycle    = 0;
      errors   = 0;
      checks   = 0;
      seenAle  = 1'b1;   // Strobe checks start with the first test's reset
      seed     = 32'd72;
      testName = "reset";

      beginTest("constants");
      emit(encL(LLI, 1, 8'h34));
      emit(encL(LUI, 1, 8'h12));
      emit(encL(LLI, 2, 8'h80));
      emit(encR(STW, 1, 2, 3));
      runTest();

      beginTest("arithmetic");
      for (int a = 0; a < 4; a++)
         mem0.mem[8'h80 + a] = randomWord();
      emit(encL(LLI, 7, 8'h80));
      emit(encR(LDW, 1, 7, 0));
      emit(encR(LDW, 2, 7, 1));
      emit(encR(ADD, 1, 2, 0));
      emit(encR(STW, 1, 7, 4));
      emit(encR(LDW, 3, 7, 2));
      emit(encR(ADDI, 3, 0, 5'h1D));   // Minus 3
      emit(encR(STW, 3, 7, 5));
      emit(encR(LDW, 4, 7, 3));
      emit(encR(SUB, 4, 2, 0));
      emit(encR(STW, 4, 7, 6));
      emit(encR(SUBI, 4, 0, 7));
      emit(encR(STW, 4, 7, 7));
      runTest();

      beginTest("carry chain");
      for (int a = 0; a < 4; a++)
         mem0.mem[8'h80 + a] = randomWord();
      // Low words make ADD carry out and SUB borrow
      mem0.mem[8'h80] = (mem0.mem[8'h80] & 16'h3FFF) | 16'h8000;
      mem0.mem[8'h82] = mem0.mem[8'h82] | 16'hC000;
      emit(encL(LLI, 7, 8'h80));
      emit(encR(LDW, 1, 7, 0));
      emit(encR(LDW, 2, 7, 1));
      emit(encR(LDW, 3, 7, 2));
      emit(encR(LDW, 4, 7, 3));
      emit(encR(ADD, 1, 3, 0));
      emit(encR(ADC, 2, 4, 0));
      emit(encR(STW, 1, 7, 4));
      emit(encR(STW, 2, 7, 5));
      emit(encR(LDW, 1, 7, 0));
      emit(encR(LDW, 2, 7, 1));
      emit(encR(SUB, 1, 3, 0));
      emit(encR(SUC, 2, 4, 0));
      emit(encR(STW, 1, 7, 6));
      emit(encR(STW, 2, 7, 7));
      runTest();

      beginTest("unimplemented");
      emit(encL(LLI, 1, 8'h5A));
      emit(encR(BR, 0, 0, 0));
      emit(encR(BNE, 3, 2, 5'h11));
      emit(encL(LLI, 7, 8'h90));
      emit(encR(STW, 1, 7, 0));
      emit(encR(JMP, 1, 7, 2));
      emit(encL(LUI, 1, 8'hA5));
      emit(encR(STW, 1, 7, 1));
      runTest();

      $display("Checks: %0d, mismatches: %0d", checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

/* cpu16.f */
verilog/opcodes.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/datapath.sv
verilog/control.sv
verilog/cpu16.sv
tb/sysBusMemory.sv
tb/cpu16_assertions.sv
tb/cpu16Tb.sv

/* run_cpu16.sh */
#!/bin/sh
# Build and run the cpu16 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu16Tb -f cpu16.f \
   -Mdir obj_dir -o simCpu16 > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/simCpu16 > sim.log 2>&1
cat sim.log

grep -q "No errors" sim.log && ! grep -q "Errors found" sim.log \
   && { echo "Simulation passed"; exit 0; } \
   || { echo "Simulation failed"; exit 1; }
